//--- include/l2_front_cfg.svh
////////////////////////////////////////////////////////////////////////////
// L2 request front end configuration
// Sizes shared by the request pipeline, the tag store and the bus side
////////////////////////////////////////////////////////////////////////////

`ifndef L2_FRONT_CFG_SVH
`define L2_FRONT_CFG_SVH

// Number of cores that can issue line reads
`define L2_NUM_CORES 4

// A request names a whole line, not a byte
`define L2_LINE_ADDR_BITS 16

// Low line address bits select one of eight direct-mapped sets
`define L2_SET_BITS 3

// One cache line is 64 bits wide
`define L2_LINE_BITS 64

// Memory side moves one 32-bit beat per Wishbone cycle
`define L2_WB_DATA_BITS 32
`define L2_BEATS_PER_LINE 2

`endif

//--- l2_request_front.f
+incdir+include
+incdir+tb
logic/l2_req_pkg.sv
logic/l2_bus_pkg.sv
logic/rr_arbiter.sv
logic/l2_cache_arb.sv
logic/l2_cache_tag.sv
logic/l2_bus_interface.sv
logic/l2_request_front.sv
tb/l2_front_tb.sv

//--- logic/l2_bus_interface.sv
////////////////////////////////////////////////////////////////////////////
// L2 bus interface
// Queues misses, fetches each line over Wishbone and restarts the
// request as a fill, skipping the fetch for a collided miss
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "l2_front_cfg.svh"

module l2_bus_interface
	import l2_req_pkg::*, l2_bus_pkg::*;
	(input clk,
	input reset,

	// From the tag stage
	input l2_request_t miss_request,

	// Wishbone master port
	output wb_master_out_t wb_out,
	input wb_master_in_t wb_in,

	// Back to the arbitration stage
	output logic restart_ready,
	output l2_request_t restart_request,
	output line_data_t restart_data,
	output logic collided,
	output logic stall);

	localparam queue_depth = 2;
	localparam ptr_bits = $clog2(queue_depth);
	localparam count_bits = $clog2(queue_depth + 1);
	localparam beat_bits = $clog2(`L2_BEATS_PER_LINE);
	localparam line_offset_bits = $clog2(`L2_LINE_BITS / 8);
	localparam beat_offset_bits = $clog2(`L2_WB_DATA_BITS / 8);

	bus_state_t state;
	miss_entry_t miss_queue[queue_depth];
	logic [ptr_bits - 1:0] head_ptr;
	logic [ptr_bits - 1:0] tail_ptr;
	logic [count_bits - 1:0] queue_count;
	logic [beat_bits - 1:0] beat;
	line_data_t line_buffer;
	line_addr_t last_line;
	logic last_valid;
	logic restart_collided;
	l2_request_t head_request;
	logic head_collides;
	logic push;
	logic pop;
	logic last_beat;

	assign head_request = miss_queue[head_ptr].request;

	// The line fetched most recently is already in the store
	assign head_collides = last_valid && last_line == head_request.line_addr;

	assign push = miss_request.valid;
	assign pop = state == bus_restart;
	assign last_beat = beat == beat_bits'(`L2_BEATS_PER_LINE - 1);

	// A miss on its way in counts too, so no more than two can pile up
	assign stall = queue_count != 0 || miss_request.valid;

	// Beat k of a line sits at byte address line * 8 + 4k
	always_comb
	begin
		wb_out.cyc = state == bus_fetch;
		wb_out.stb = state == bus_fetch;
		wb_out.we = 1'b0;
		wb_out.sel = '1;
		wb_out.adr = (wb_addr_t'(head_request.line_addr) << line_offset_bits)
			+ (wb_addr_t'(beat) << beat_offset_bits);
	end

	// Restart lasts exactly one cycle in the restart state
	always_comb
	begin
		restart_ready = state == bus_restart;
		restart_request = head_request;
		restart_request.valid = restart_ready;
		restart_data = line_buffer;
		collided = restart_ready && restart_collided;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= bus_idle;
			head_ptr <= '0;
			tail_ptr <= '0;
			queue_count <= '0;
			beat <= '0;
			last_valid <= 1'b0;
			restart_collided <= 1'b0;
		end
		else
		begin
			if (push)
				tail_ptr <= tail_ptr + 1'b1;
			if (pop)
				head_ptr <= head_ptr + 1'b1;
			queue_count <= queue_count + count_bits'(push) - count_bits'(pop);

			case (state)
				bus_idle:
				begin
					if (queue_count != 0)
					begin
						restart_collided <= head_collides;
						beat <= '0;
						state <= head_collides ? bus_restart : bus_fetch;
					end
				end

				bus_fetch:
				begin
					// Each beat is its own classic cycle, ended by ack
					if (wb_in.ack)
					begin
						if (last_beat)
						begin
							last_valid <= 1'b1;
							state <= bus_restart;
						end
						else
							beat <= beat + 1'b1;
					end
				end

				bus_restart:
					state <= bus_idle;

				default:
					state <= bus_idle;
			endcase
		end
	end

	// Queue storage and the assembled line
	always_ff @(posedge clk)
	begin
		if (push)
			miss_queue[tail_ptr].request <= miss_request;
		if (state == bus_fetch && wb_in.ack)
		begin
			line_buffer[beat * `L2_WB_DATA_BITS +: `L2_WB_DATA_BITS] <= wb_in.dat_i;
			last_line <= head_request.line_addr;
		end
	end
endmodule

//--- logic/l2_bus_pkg.sv
////////////////////////////////////////////////////////////////////////////
// L2 bus side types
// Wishbone classic master signals and the miss queue entry
////////////////////////////////////////////////////////////////////////////

`include "l2_front_cfg.svh"

package l2_bus_pkg;

	import l2_req_pkg::*;

	// Byte address and data of one beat on the bus
	typedef logic [31:0] wb_addr_t;
	typedef logic [`L2_WB_DATA_BITS - 1:0] wb_data_t;

	// Signals driven by the master
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_addr_t adr;
		logic [`L2_WB_DATA_BITS / 8 - 1:0] sel;
	} wb_master_out_t;

	// Signals returned by the slave
	typedef struct packed {
		logic ack;
		wb_data_t dat_i;
	} wb_master_in_t;

	// One outstanding miss waiting for its line
	typedef struct packed {
		l2_request_t request;
	} miss_entry_t;

	// Miss handling FSM
	typedef enum logic [1:0] {
		bus_idle,
		bus_fetch,
		bus_restart
	} bus_state_t;

endpackage

//--- logic/l2_cache_arb.sv
////////////////////////////////////////////////////////////////////////////
// L2 arbitration stage
// Picks a restarted miss or one core request and registers it for the
// tag stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "l2_front_cfg.svh"

module l2_cache_arb
	import l2_req_pkg::*;
	(input clk,
	input reset,

	// Core side
	input l2_request_t core_request[`L2_NUM_CORES],
	output logic core_ready[`L2_NUM_CORES],

	// Toward the tag stage
	output l2_request_t arb_request,
	output line_data_t arb_data,
	output logic arb_is_fill,

	// From the bus interface
	input restart_ready,
	input l2_request_t restart_request,
	input line_data_t restart_data,
	input stall,
	input collided);

	logic [`L2_NUM_CORES - 1:0] core_valid;
	logic [`L2_NUM_CORES - 1:0] grant_oh;
	logic can_accept;
	l2_request_t granted_request;

	// Cores wait in reset, while a restart owns the stage or while misses are outstanding
	assign can_accept = !reset && !restart_ready && !stall;

	rr_arbiter #(.num_requests(`L2_NUM_CORES)) core_arbiter(
		.clk(clk),
		.reset(reset),
		.request(core_valid),
		.update(can_accept),
		.grant_oh(grant_oh));

	// Ready depends combinationally on the valid bits of the requests
	always_comb
	begin
		granted_request = '0;
		for (int i = 0; i < `L2_NUM_CORES; i++)
		begin
			core_valid[i] = core_request[i].valid;
			core_ready[i] = grant_oh[i] && can_accept;
			if (grant_oh[i])
				granted_request = core_request[i];
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			arb_request <= '0;
			arb_is_fill <= 1'b0;
		end
		else if (restart_ready)
		begin
			// A collided miss already has its line in the store, so it runs as
			// a plain read
			arb_request <= restart_request;
			arb_is_fill <= !collided;
		end
		else if (|grant_oh && can_accept)
		begin
			arb_request <= granted_request;
			arb_is_fill <= 1'b0;
		end
		else
		begin
			arb_request.valid <= 1'b0;
			arb_is_fill <= 1'b0;
		end
	end

	// Restart data travels with the restarted packet into the tag stage
	always_ff @(posedge clk)
	begin
		if (restart_ready)
			arb_data <= restart_data;
	end
endmodule

//--- logic/l2_cache_tag.sv
////////////////////////////////////////////////////////////////////////////
// L2 tag stage
// Direct-mapped tag and line store; answers hits, writes fills and
// passes misses on to the bus interface
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "l2_front_cfg.svh"

module l2_cache_tag
	import l2_req_pkg::*;
	(input clk,
	input reset,

	// From the arbitration stage
	input l2_request_t arb_request,
	input line_data_t arb_data,
	input arb_is_fill,

	// To the cores
	output l2_response_t response,

	// To the bus interface
	output l2_request_t miss_request);

	localparam num_sets = 1 << `L2_SET_BITS;
	localparam tag_bits = `L2_LINE_ADDR_BITS - `L2_SET_BITS;

	logic [tag_bits - 1:0] tag_store[num_sets];
	line_data_t line_store[num_sets];
	logic [num_sets - 1:0] tag_valid;
	logic [`L2_SET_BITS - 1:0] set_idx;
	logic [tag_bits - 1:0] req_tag;
	logic write_fill;
	logic hit;

	// Low bits pick the set, the rest is compared as the tag
	assign set_idx = arb_request.line_addr[`L2_SET_BITS - 1:0];
	assign req_tag = arb_request.line_addr[`L2_LINE_ADDR_BITS - 1:`L2_SET_BITS];

	assign write_fill = arb_request.valid && arb_is_fill;
	assign hit = tag_valid[set_idx] && tag_store[set_idx] == req_tag;

	// A fill simply replaces whatever line the set held before
	always_ff @(posedge clk)
	begin
		if (write_fill)
		begin
			tag_store[set_idx] <= req_tag;
			line_store[set_idx] <= arb_data;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			tag_valid <= '0;
		else if (write_fill)
			tag_valid[set_idx] <= 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			response <= '0;
			miss_request <= '0;
		end
		else
		begin
			// Both outputs are single-cycle pulses
			response.valid <= 1'b0;
			miss_request.valid <= 1'b0;
			if (arb_request.valid)
			begin
				if (arb_is_fill)
				begin
					// Fill data goes straight back to the core that missed
					response.valid <= 1'b1;
					response.core_id <= arb_request.core_id;
					response.line_addr <= arb_request.line_addr;
					response.data <= arb_data;
				end
				else if (hit)
				begin
					response.valid <= 1'b1;
					response.core_id <= arb_request.core_id;
					response.line_addr <= arb_request.line_addr;
					response.data <= line_store[set_idx];
				end
				else
					miss_request <= arb_request;
			end
		end
	end
endmodule

//--- logic/l2_req_pkg.sv
////////////////////////////////////////////////////////////////////////////
// L2 request types
// Core-side request and response packets and the packet that moves
// between the arbitration and tag stages
////////////////////////////////////////////////////////////////////////////

`include "l2_front_cfg.svh"

package l2_req_pkg;

	// Address of one cache line
	typedef logic [`L2_LINE_ADDR_BITS - 1:0] line_addr_t;

	// Contents of one cache line
	typedef logic [`L2_LINE_BITS - 1:0] line_data_t;

	// Index of the requesting core, carried so the response finds its way back
	typedef logic [$clog2(`L2_NUM_CORES) - 1:0] core_id_t;

	// A read request from a core, also used as the pipeline packet
	typedef struct packed {
		logic valid;
		core_id_t core_id;
		line_addr_t line_addr;
	} l2_request_t;

	// A response always carries a full line
	typedef struct packed {
		logic valid;
		core_id_t core_id;
		line_addr_t line_addr;
		line_data_t data;
	} l2_response_t;

endpackage

//--- logic/l2_request_front.sv
////////////////////////////////////////////////////////////////////////////
// L2 request front end
// Arbitration stage, tag stage and Wishbone bus interface
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "l2_front_cfg.svh"

module l2_request_front
	import l2_req_pkg::*, l2_bus_pkg::*;
	(input clk,
	input reset,

	// Cores
	input l2_request_t core_request[`L2_NUM_CORES],
	output logic core_ready[`L2_NUM_CORES],
	output l2_response_t response,

	// Memory
	output wb_master_out_t wb_out,
	input wb_master_in_t wb_in);

	// Arbitration to tag stage
	l2_request_t arb_request;
	line_data_t arb_data;
	logic arb_is_fill;

	// Tag stage to bus interface
	l2_request_t miss_request;

	// Bus interface back to arbitration
	logic restart_ready;
	l2_request_t restart_request;
	line_data_t restart_data;
	logic collided;
	logic stall;

	l2_cache_arb cache_arb(.*);

	l2_cache_tag cache_tag(.*);

	l2_bus_interface bus_interface(.*);
endmodule

//--- logic/rr_arbiter.sv
////////////////////////////////////////////////////////////////////////////
// Round-robin arbiter
// Grants the first requester after the last winner, one-hot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module rr_arbiter
	#(parameter num_requests = 4)
	(input clk,
	input reset,
	input [num_requests - 1:0] request,
	input update,
	output logic [num_requests - 1:0] grant_oh);

	localparam idx_bits = num_requests > 1 ? $clog2(num_requests) : 1;

	logic [idx_bits - 1:0] last_winner;
	logic [idx_bits - 1:0] grant_idx;

	// Search starts one past the last winner and wraps around,
	// so the last winner itself has the lowest priority
	always_comb
	begin : grant_search
		int candidate;
		logic found;

		grant_oh = '0;
		grant_idx = last_winner;
		found = 1'b0;
		for (int offset = 1; offset <= num_requests; offset++)
		begin
			candidate = (int'(last_winner) + offset) % num_requests;
			if (!found && request[candidate])
			begin
				found = 1'b1;
				grant_oh[candidate] = 1'b1;
				grant_idx = idx_bits'(candidate);
			end
		end
	end

	// Priority only moves when the grant is actually taken
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			last_winner <= idx_bits'(num_requests - 1);
		else if (update && |grant_oh)
			last_winner <= grant_idx;
	end
endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the L2 request front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary -j 0 --top-module l2_front_tb -f l2_request_front.f -o l2_front_sim

output=$(./obj_dir/l2_front_sim)
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
	exit 0
fi
echo "simulation did not pass"
exit 1

//--- tb/l2_front_stim.svh
////////////////////////////////////////////////////////////////////////////
// L2 front end stimulus
// Request table for the cores and the contents rule of the memory model
////////////////////////////////////////////////////////////////////////////

`ifndef L2_FRONT_STIM_SVH
`define L2_FRONT_STIM_SVH

// Each row holds a core, a line address, a start cycle and the expected kind
localparam int num_rows = 16;

// A fetch row reads its line over the bus, a hit row is answered from the
// store, and a collided row rides on the fetch of the row before it
localparam logic [1:0] kind_fetch = 2'd0;
localparam logic [1:0] kind_hit = 2'd1;
localparam logic [1:0] kind_collide = 2'd2;

typedef struct packed {
	core_id_t core;
	line_addr_t line_addr;
	logic [15:0] start_cycle;
	logic [1:0] kind;
} stim_row_t;

function automatic stim_row_t table_row(input int idx);
	stim_row_t row;
	case (idx)
		// Cold read, then the same line again
		0: row = '{core: 2'd0, line_addr: 16'h0010, start_cycle: 16'd2, kind: kind_fetch};
		1: row = '{core: 2'd0, line_addr: 16'h0010, start_cycle: 16'd20, kind: kind_hit};
		// All four cores at once, each line in its own set
		2: row = '{core: 2'd0, line_addr: 16'h0121, start_cycle: 16'd80, kind: kind_fetch};
		3: row = '{core: 2'd1, line_addr: 16'h0232, start_cycle: 16'd80, kind: kind_fetch};
		4: row = '{core: 2'd2, line_addr: 16'h0343, start_cycle: 16'd80, kind: kind_fetch};
		5: row = '{core: 2'd3, line_addr: 16'h0454, start_cycle: 16'd80, kind: kind_fetch};
		// Core 1 asks again while cores 3 and 0 still wait their turn
		6: row = '{core: 2'd1, line_addr: 16'h0232, start_cycle: 16'd80, kind: kind_hit};
		// Two misses to one line, taken on back-to-back cycles
		7: row = '{core: 2'd2, line_addr: 16'h0066, start_cycle: 16'd200, kind: kind_fetch};
		8: row = '{core: 2'd1, line_addr: 16'h0066, start_cycle: 16'd200, kind: kind_collide};
		// Lines 0015 and 0025 share set 5 and push each other out
		9: row = '{core: 2'd3, line_addr: 16'h0015, start_cycle: 16'd280, kind: kind_fetch};
		10: row = '{core: 2'd3, line_addr: 16'h0025, start_cycle: 16'd290, kind: kind_fetch};
		11: row = '{core: 2'd3, line_addr: 16'h0015, start_cycle: 16'd300, kind: kind_fetch};
		// Other cores wait behind an outstanding miss
		12: row = '{core: 2'd0, line_addr: 16'h0777, start_cycle: 16'd400, kind: kind_fetch};
		13: row = '{core: 2'd1, line_addr: 16'h0232, start_cycle: 16'd401, kind: kind_hit};
		14: row = '{core: 2'd2, line_addr: 16'h0343, start_cycle: 16'd401, kind: kind_hit};
		15: row = '{core: 2'd3, line_addr: 16'h0454, start_cycle: 16'd401, kind: kind_hit};
		default: row = '0;
	endcase
	return row;
endfunction

// Memory answers each beat with its byte address xor a fixed pattern
function automatic line_data_t expected_line(input line_addr_t line_addr);
	wb_addr_t byte_addr;
	line_data_t line;
	byte_addr = {13'b0, line_addr, 3'b000};
	for (int k = 0; k < `L2_BEATS_PER_LINE; k++)
		line[k * `L2_WB_DATA_BITS +: `L2_WB_DATA_BITS] = (byte_addr + wb_addr_t'(4 * k)) ^ 32'h5a5a0000;
	return line;
endfunction

`endif

//--- tb/l2_front_tb.sv
////////////////////////////////////////////////////////////////////////////
// L2 request front end testbench
// Drives a request table through the cores, models a Wishbone memory
// and scores every response against the memory contents rule
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "l2_front_cfg.svh"

module l2_front_tb
	import l2_req_pkg::*, l2_bus_pkg::*;
	();

	`include "l2_front_stim.svh"

	localparam int timeout_cycles = num_rows * 60;

	logic clk;
	logic reset;
	l2_request_t core_request[`L2_NUM_CORES];
	logic core_ready[`L2_NUM_CORES];
	l2_response_t response;
	wb_master_out_t wb_out;
	wb_master_in_t wb_in;

	int seed;
	int cycle;
	int error_count;
	int rows_done;
	int rows_passed;
	int beat_count;
	int ack_wait;
	logic ack_armed;
	logic timed_out;

	// Row each core works on (-1 when idle) and whether it was taken yet
	int active_row[`L2_NUM_CORES];
	int next_row[`L2_NUM_CORES];
	logic accepted[`L2_NUM_CORES];
	// Cores granted while this one was kept waiting
	logic [`L2_NUM_CORES - 1:0] passed_by[`L2_NUM_CORES];
	int accept_cycle[num_rows];
	int accept_beats[num_rows];

	l2_request_front dut0(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic check_line(input line_data_t expected, input line_data_t actual,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_core(input core_id_t expected, input core_id_t actual, input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_addr(input line_addr_t expected, input line_addr_t actual,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic report_error(input string what);
		$display("Error at %0t: %s", $time, what);
		error_count++;
	endtask

	function automatic int count_expected_beats();
		stim_row_t row;
		int beats;
		beats = 0;
		for (int r = 0; r < num_rows; r++)
		begin
			row = table_row(r);
			if (row.kind == kind_fetch)
				beats += `L2_BEATS_PER_LINE;
		end
		return beats;
	endfunction

	// Each core starts its next row once the previous one is answered
	task automatic drive_requests();
		stim_row_t row;
		for (int c = 0; c < `L2_NUM_CORES; c++)
		begin
			if (accepted[c])
				core_request[c].valid = 1'b0;
			if (active_row[c] < 0)
			begin
				row = table_row(next_row[c]);
				while (next_row[c] < num_rows && int'(row.core) != c)
				begin
					next_row[c]++;
					row = table_row(next_row[c]);
				end
				if (next_row[c] < num_rows && cycle >= int'(row.start_cycle))
				begin
					active_row[c] = next_row[c];
					next_row[c]++;
					accepted[c] = 1'b0;
					core_request[c] = '{valid: 1'b1, core_id: row.core, line_addr: row.line_addr};
				end
			end
		end
	endtask

	// Slave holds off each strobe for 0 to 2 cycles, then acks it
	task automatic drive_memory();
		wb_in.ack = 1'b0;
		if (wb_out.cyc && wb_out.stb)
		begin
			if (!ack_armed)
			begin
				ack_wait = $unsigned($random(seed)) % 3;
				ack_armed = 1'b1;
			end
			if (ack_wait == 0)
			begin
				wb_in.ack = 1'b1;
				wb_in.dat_i = wb_out.adr ^ 32'h5a5a0000;
				ack_armed = 1'b0;
			end
			else
				ack_wait--;
		end
	endtask

	task automatic note_grant(input int c);
		int r;
		r = active_row[c];
		accepted[c] = 1'b1;
		accept_cycle[r] = cycle;
		accept_beats[r] = beat_count;
		// Round robin lets every other waiting core in before c comes back
		for (int d = 0; d < `L2_NUM_CORES; d++)
		begin
			if (d != c && active_row[d] >= 0 && !accepted[d])
			begin
				if (passed_by[d][c])
					report_error($sformatf("core %0d was skipped twice for core %0d", d, c));
				passed_by[d][c] = 1'b1;
			end
		end
		passed_by[c] = '0;
	endtask

	task automatic finish_row();
		stim_row_t row;
		int c;
		int r;
		int errors_before;
		c = int'(response.core_id);
		r = active_row[c];
		if (r < 0 || !accepted[c])
			report_error($sformatf("response for core %0d with no request outstanding", c));
		else
		begin
			row = table_row(r);
			errors_before = error_count;
			check_addr(row.line_addr, response.line_addr, $sformatf("row %0d address", r));
			check_line(expected_line(row.line_addr), response.data, $sformatf("row %0d line", r));
			if (row.kind == kind_hit && cycle - accept_cycle[r] != 2)
				report_error($sformatf("row %0d hit took %0d cycles", r, cycle - accept_cycle[r]));
			if (row.kind == kind_hit && beat_count != accept_beats[r])
				report_error($sformatf("row %0d hit but a Wishbone fetch ran", r));
			if (row.kind == kind_fetch && beat_count - accept_beats[r] < `L2_BEATS_PER_LINE)
				report_error($sformatf("row %0d was answered without a line fetch", r));
			if (error_count == errors_before)
				rows_passed++;
			$display("row %0d core %0d line %h %s: %s after %0d cycles", r, c, row.line_addr,
				row.kind == kind_hit ? "hit" : "miss", error_count == errors_before ? "pass" : "fail",
				cycle - accept_cycle[r]);
			active_row[c] = -1;
			rows_done++;
		end
	endtask

	task automatic sample_cycle();
		stim_row_t row;
		int ready_count;
		ready_count = 0;
		if (wb_out.cyc && wb_out.stb && wb_in.ack)
			beat_count++;
		// Every beat is a read of a whole 32-bit word
		if (wb_out.cyc && wb_out.stb && (wb_out.we || wb_out.sel != '1))
			report_error("a line fetch beat was not a full-word read");
		for (int c = 0; c < `L2_NUM_CORES; c++)
		begin
			if (core_ready[c])
			begin
				ready_count++;
				if (active_row[c] >= 0 && !accepted[c])
					note_grant(c);
			end
		end
		if (ready_count > 1)
			report_error("more than one core was ready in the same cycle");
		if (ready_count > 0 && wb_out.cyc)
			report_error("a core was ready while a line fetch was running");
		// A hit is due exactly two cycles after its accepting edge
		for (int c = 0; c < `L2_NUM_CORES; c++)
		begin
			if (active_row[c] >= 0 && accepted[c])
			begin
				row = table_row(active_row[c]);
				if (row.kind == kind_hit && cycle == accept_cycle[active_row[c]] + 2)
				begin
					if (!response.valid)
						report_error($sformatf("no response two cycles after hit of core %0d", c));
					else
						check_core(core_id_t'(c), response.core_id, "core of hit response");
				end
			end
		end
		if (response.valid)
			finish_row();
	endtask

	// Inputs change on the falling edge, outputs are read 1 ns later
	task automatic run_cycle();
		@(negedge clk);
		cycle++;
		drive_requests();
		drive_memory();
		#1;
		sample_cycle();
	endtask

	initial
	begin
		seed = 32'h6d0f;
		cycle = 0;
		error_count = 0;
		rows_done = 0;
		rows_passed = 0;
		beat_count = 0;
		ack_wait = 0;
		ack_armed = 1'b0;
		wb_in = '0;
		for (int c = 0; c < `L2_NUM_CORES; c++)
		begin
			// Every core asks during reset, and none of them may see ready
			core_request[c] = '{valid: 1'b1, core_id: core_id_t'(c), line_addr: line_addr_t'(c)};
			active_row[c] = -1;
			next_row[c] = 0;
			accepted[c] = 1'b0;
			passed_by[c] = '0;
		end
		reset = 1'b1;
		repeat (3)
		begin
			@(posedge clk);
			#1;
			for (int c = 0; c < `L2_NUM_CORES; c++)
				if (core_ready[c])
					report_error($sformatf("ready of core %0d was high during reset", c));
		end
		@(negedge clk);
		// Cores drop their requests as they leave reset
		for (int c = 0; c < `L2_NUM_CORES; c++)
			core_request[c] = '0;
		reset = 1'b0;

		while (rows_done < num_rows && cycle < timeout_cycles)
			run_cycle();
		timed_out = rows_done < num_rows;
		if (timed_out)
			$display("run timed out after %0d cycles with %0d of %0d rows answered", cycle,
				rows_done, num_rows);
		else
		begin
			// A few idle cycles catch any stray response
			repeat (8)
				run_cycle();
			if (beat_count != count_expected_beats())
			begin
				$display("[FAIL] %0t: %0d Wishbone beats seen, expected %0d", $time, beat_count,
					count_expected_beats());
				error_count++;
			end
		end
		$display("%0d of %0d rows passed, %0d errors", rows_passed, num_rows, error_count);
		if (!timed_out && error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end
endmodule
